// File: bayer_demosaic.f
logic/bayer_pkg.sv
logic/raw_capture.sv
logic/line_window.sv
logic/bayer_kernel_table.sv
logic/conv3x3.sv
logic/demosaic_core.sv
logic/bayer_demosaic_top.sv
test/tb_clock_gen.sv
test/tb_bayer_demosaic.sv

// File: logic/bayer_demosaic_top.sv
`default_nettype none
`timescale 1ns/1ps

module bayer_demosaic_top (
    input  wire                     w_clk_100MHz_to_25MHz,
    input  wire                     rst_i,
    input  wire                     vsync_i,
    input  wire                     href_i,
    input  wire bayer_pkg::raw_t    data_i,
    output logic                    valid_o,
    output bayer_pkg::rgb_t         rgb_o,
    output bayer_pkg::row_t         row_o,
    output bayer_pkg::col_t         col_o
);

    logic              pix_valid;
    bayer_pkg::pixel_t pix;
    bayer_pkg::row_t   pix_row;
    bayer_pkg::col_t   pix_col;
    logic              win_valid;
    bayer_pkg::pixel_t win_taps [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE];
    bayer_pkg::row_t   win_row;
    bayer_pkg::col_t   win_col;

    ////////////////////////////////////////////////////////////////////////////
    // sensor side

    raw_capture i_raw_capture (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst_i),
        .vsync_i               (vsync_i),
        .href_i                (href_i),
        .data_i                (data_i),
        .pix_valid_o           (pix_valid),
        .pix_o                 (pix),
        .pix_row_o             (pix_row),
        .pix_col_o             (pix_col)
    );

    line_window i_line_window (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst_i),
        .pix_valid_i           (pix_valid),
        .pix_i                 (pix),
        .pix_row_i             (pix_row),
        .pix_col_i             (pix_col),
        .win_valid_o           (win_valid),
        .win_taps_o            (win_taps),
        .win_row_o             (win_row),
        .win_col_o             (win_col)
    );

    ////////////////////////////////////////////////////////////////////////////
    // color reconstruction

    demosaic_core i_demosaic_core (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst_i),
        .win_valid_i           (win_valid),
        .win_taps_i            (win_taps),
        .win_row_i             (win_row),
        .win_col_i             (win_col),
        .valid_o               (valid_o),
        .rgb_o                 (rgb_o),
        .row_o                 (row_o),
        .col_o                 (col_o)
    );

endmodule

`default_nettype wire

// File: logic/bayer_kernel_table.sv
`default_nettype none
`timescale 1ns/1ps

module bayer_kernel_table (
    input  wire bayer_pkg::row_t    row_i,
    input  wire bayer_pkg::col_t    col_i,
    output bayer_pkg::coeff_t       red_coeffs_o  [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE],
    output bayer_pkg::coeff_t       blue_coeffs_o [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE]
);

    localparam bayer_pkg::coeff_t ONE = bayer_pkg::coeff_t'(bayer_pkg::COEFF_ONE);
    localparam bayer_pkg::coeff_t HALF = bayer_pkg::coeff_t'(bayer_pkg::COEFF_HALF);
    localparam bayer_pkg::coeff_t QUARTER = bayer_pkg::coeff_t'(bayer_pkg::COEFF_QUARTER);

    always_comb begin
        for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
            for (int x = 0; x < bayer_pkg::KERNEL_SIZE; x++) begin
                red_coeffs_o[y][x]  = '0;
                blue_coeffs_o[y][x] = '0;
            end
        end

        // phase is {row odd, col odd}
        case ({row_i[0], col_i[0]})
            2'b11: begin
                // red site
                red_coeffs_o[1][1]  = ONE;
                blue_coeffs_o[0][0] = QUARTER;
                blue_coeffs_o[0][2] = QUARTER;
                blue_coeffs_o[2][0] = QUARTER;
                blue_coeffs_o[2][2] = QUARTER;
            end
            2'b10: begin
                // green site, red to the sides
                red_coeffs_o[1][0]  = HALF;
                red_coeffs_o[1][2]  = HALF;
                blue_coeffs_o[0][1] = HALF;
                blue_coeffs_o[2][1] = HALF;
            end
            2'b01: begin
                // green site, red above and below
                red_coeffs_o[0][1]  = HALF;
                red_coeffs_o[2][1]  = HALF;
                blue_coeffs_o[1][0] = HALF;
                blue_coeffs_o[1][2] = HALF;
            end
            default: begin
                // blue site
                red_coeffs_o[0][0]  = QUARTER;
                red_coeffs_o[0][2]  = QUARTER;
                red_coeffs_o[2][0]  = QUARTER;
                red_coeffs_o[2][2]  = QUARTER;
                blue_coeffs_o[1][1] = ONE;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/bayer_pkg.sv
`default_nettype none

package bayer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // frame geometry

    localparam int IMAGE_WIDTH = 640;
    localparam int IMAGE_HEIGHT = 480;

    // window edge, taps are [row][col] with row 0 on top
    localparam int KERNEL_SIZE = 3;

    ////////////////////////////////////////////////////////////////////////////
    // fixed point

    // coefficients are uq1.8
    localparam int COEFF_FRAC_BITS = 8;

    // largest 4-bit channel sample
    localparam int PIXEL_MAX = 15;

    // common uq1.8 weights of the bayer kernels
    localparam int COEFF_ONE = 1 << COEFF_FRAC_BITS;
    localparam int COEFF_HALF = COEFF_ONE >> 1;
    localparam int COEFF_QUARTER = COEFF_ONE >> 2;

    ////////////////////////////////////////////////////////////////////////////
    // vector types

    // one sensor byte
    typedef logic [7:0] raw_t;

    // one channel sample, upper nibble of the sensor byte
    typedef logic [3:0] pixel_t;

    // positions inside the frame
    typedef logic [8:0] row_t;
    typedef logic [9:0] col_t;

    // uq1.8 coefficient
    typedef logic [8:0] coeff_t;

    // sum of nine pixel by coefficient products
    typedef logic [15:0] acc_t;

    // red in the top nibble, then green, then blue
    typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire

// File: logic/conv3x3.sv
`default_nettype none
`timescale 1ns/1ps

module conv3x3 (
    input  wire                       w_clk_100MHz_to_25MHz,
    input  wire                       rst_i,
    input  wire                       valid_i,
    input  wire bayer_pkg::pixel_t    taps_i   [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE],
    input  wire bayer_pkg::coeff_t    coeffs_i [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE],
    output logic                      valid_o,
    output bayer_pkg::pixel_t         result_o
);

    bayer_pkg::acc_t prod_q [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE];
    logic            prod_valid;
    bayer_pkg::acc_t sum;
    bayer_pkg::acc_t scaled;
    logic            clamp_hit;
    bayer_pkg::acc_t coeff_sum;

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        if (rst_i) begin
            prod_valid <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            prod_valid <= valid_i;
            valid_o    <= prod_valid;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, products

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
            for (int x = 0; x < bayer_pkg::KERNEL_SIZE; x++) begin
                prod_q[y][x] <= bayer_pkg::acc_t'(taps_i[y][x]) * bayer_pkg::acc_t'(coeffs_i[y][x]);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, sum, truncate and clamp

    always_comb begin
        sum = '0;
        for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
            for (int x = 0; x < bayer_pkg::KERNEL_SIZE; x++) begin
                sum = sum + prod_q[y][x];
            end
        end
        scaled    = sum >> bayer_pkg::COEFF_FRAC_BITS;
        clamp_hit = scaled > bayer_pkg::acc_t'(bayer_pkg::PIXEL_MAX);
    end

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        result_o <= clamp_hit ? bayer_pkg::pixel_t'(bayer_pkg::PIXEL_MAX) : scaled[3:0];
    end

    // weight of the incoming kernel
    always_comb begin
        coeff_sum = '0;
        for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
            for (int x = 0; x < bayer_pkg::KERNEL_SIZE; x++) begin
                coeff_sum = coeff_sum + bayer_pkg::acc_t'(coeffs_i[y][x]);
            end
        end
    end

    // a kernel of unit gain or less can not saturate one cycle later
    assert property (@(posedge w_clk_100MHz_to_25MHz) disable iff (rst_i)
        (valid_i && coeff_sum <= bayer_pkg::acc_t'(bayer_pkg::COEFF_ONE)) |=> !clamp_hit);

endmodule

`default_nettype wire

// File: logic/demosaic_core.sv
`default_nettype none
`timescale 1ns/1ps

module demosaic_core (
    input  wire                       w_clk_100MHz_to_25MHz,
    input  wire                       rst_i,
    input  wire                       win_valid_i,
    input  wire bayer_pkg::pixel_t    win_taps_i [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE],
    input  wire bayer_pkg::row_t      win_row_i,
    input  wire bayer_pkg::col_t      win_col_i,
    output logic                      valid_o,
    output bayer_pkg::rgb_t           rgb_o,
    output bayer_pkg::row_t           row_o,
    output bayer_pkg::col_t           col_o
);

    bayer_pkg::coeff_t red_coeffs  [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE];
    bayer_pkg::coeff_t blue_coeffs [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE];
    logic              red_valid;
    bayer_pkg::pixel_t red;
    bayer_pkg::pixel_t blue;
    bayer_pkg::pixel_t green_q [2];
    bayer_pkg::row_t   row_q   [2];
    bayer_pkg::col_t   col_q   [2];

    bayer_kernel_table i_bayer_kernel_table (
        .row_i         (win_row_i),
        .col_i         (win_col_i),
        .red_coeffs_o  (red_coeffs),
        .blue_coeffs_o (blue_coeffs)
    );

    conv3x3 i_conv_red (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst_i),
        .valid_i               (win_valid_i),
        .taps_i                (win_taps_i),
        .coeffs_i              (red_coeffs),
        .valid_o               (red_valid),
        .result_o              (red)
    );

    conv3x3 i_conv_blue (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst_i),
        .valid_i               (win_valid_i),
        .taps_i                (win_taps_i),
        .coeffs_i              (blue_coeffs),
        .valid_o               (),
        .result_o              (blue)
    );

    // green is the center tap, delayed like the convolvers
    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        green_q[0] <= win_taps_i[1][1];
        green_q[1] <= green_q[0];
        row_q[0]   <= win_row_i;
        row_q[1]   <= row_q[0];
        col_q[0]   <= win_col_i;
        col_q[1]   <= col_q[0];
    end

    assign valid_o = red_valid;
    assign rgb_o   = {red, green_q[1], blue};
    assign row_o   = row_q[1];
    assign col_o   = col_q[1];

endmodule

`default_nettype wire

// File: logic/line_window.sv
`default_nettype none
`timescale 1ns/1ps

module line_window (
    input  wire                       w_clk_100MHz_to_25MHz,
    input  wire                       rst_i,
    input  wire                       pix_valid_i,
    input  wire bayer_pkg::pixel_t    pix_i,
    input  wire bayer_pkg::row_t      pix_row_i,
    input  wire bayer_pkg::col_t      pix_col_i,
    output logic                      win_valid_o,
    output bayer_pkg::pixel_t         win_taps_o [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE],
    output bayer_pkg::row_t           win_row_o,
    output bayer_pkg::col_t           win_col_o
);

    // line buffers, near holds the previous row, far the one before
    bayer_pkg::pixel_t line_near [bayer_pkg::IMAGE_WIDTH];
    bayer_pkg::pixel_t line_far  [bayer_pkg::IMAGE_WIDTH];
    bayer_pkg::pixel_t win_q     [bayer_pkg::KERNEL_SIZE][bayer_pkg::KERNEL_SIZE];

    logic              flush_active;
    bayer_pkg::col_t   flush_cnt;
    logic              in_valid;
    bayer_pkg::pixel_t in_pix;
    bayer_pkg::row_t   in_row;
    bayer_pkg::col_t   in_col;
    bayer_pkg::row_t   ctr_row;
    bayer_pkg::col_t   ctr_col;
    logic              ctr_ok;

    ////////////////////////////////////////////////////////////////////////////
    // input stream, real pixels or flush zeros past the frame

    always_comb begin
        in_valid = pix_valid_i || flush_active;
        in_pix   = flush_active ? '0 : pix_i;
        in_row   = pix_row_i;
        in_col   = pix_col_i;
        if (flush_active) begin
            if (flush_cnt == bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH)) begin
                in_row = bayer_pkg::row_t'(bayer_pkg::IMAGE_HEIGHT + 1);
                in_col = '0;
            end else begin
                in_row = bayer_pkg::row_t'(bayer_pkg::IMAGE_HEIGHT);
                in_col = flush_cnt;
            end
        end
    end

    // center trails the input by one line and one pixel
    always_comb begin
        if (in_col == '0) begin
            ctr_row = in_row - bayer_pkg::row_t'(2);
            ctr_col = bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH - 1);
        end else begin
            ctr_row = in_row - bayer_pkg::row_t'(1);
            ctr_col = in_col - bayer_pkg::col_t'(1);
        end
        ctr_ok = (in_row > bayer_pkg::row_t'(1)) || (in_row == bayer_pkg::row_t'(1) && in_col != '0);
    end

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        if (rst_i) begin
            flush_active <= 1'b0;
            flush_cnt    <= '0;
            win_valid_o  <= 1'b0;
        end else begin
            win_valid_o <= in_valid && ctr_ok;
            if (pix_valid_i && pix_row_i == bayer_pkg::row_t'(bayer_pkg::IMAGE_HEIGHT - 1) &&
                pix_col_i == bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH - 1)) begin
                flush_active <= 1'b1;
                flush_cnt    <= '0;
            end else if (flush_active) begin
                flush_cnt <= flush_cnt + 1'b1;
                if (flush_cnt == bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH)) begin
                    flush_active <= 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // line buffers and shift window

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        if (in_valid) begin
            for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
                win_q[y][0] <= win_q[y][1];
                win_q[y][1] <= win_q[y][2];
            end
            win_q[0][2]       <= line_far[in_col];
            win_q[1][2]       <= line_near[in_col];
            win_q[2][2]       <= in_pix;
            line_far[in_col]  <= line_near[in_col];
            line_near[in_col] <= in_pix;
            win_row_o         <= ctr_row;
            win_col_o         <= ctr_col;
        end
    end

    // taps that fall outside the frame read as zero
    always_comb begin
        for (int y = 0; y < bayer_pkg::KERNEL_SIZE; y++) begin
            for (int x = 0; x < bayer_pkg::KERNEL_SIZE; x++) begin
                win_taps_o[y][x] = win_q[y][x];
                if ((y == 0 && win_row_o == '0) ||
                    (y == 2 && win_row_o == bayer_pkg::row_t'(bayer_pkg::IMAGE_HEIGHT - 1)) ||
                    (x == 0 && win_col_o == '0) ||
                    (x == 2 && win_col_o == bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH - 1))) begin
                    win_taps_o[y][x] = '0;
                end
            end
        end
    end

    // vertical blanking must cover the whole flush
    assert property (@(posedge w_clk_100MHz_to_25MHz) disable iff (rst_i)
        flush_active |-> !pix_valid_i);

endmodule

`default_nettype wire

// File: logic/raw_capture.sv
`default_nettype none
`timescale 1ns/1ps

module raw_capture (
    input  wire                     w_clk_100MHz_to_25MHz,
    input  wire                     rst_i,
    input  wire                     vsync_i,
    input  wire                     href_i,
    input  wire bayer_pkg::raw_t    data_i,
    output logic                    pix_valid_o,
    output bayer_pkg::pixel_t       pix_o,
    output bayer_pkg::row_t         pix_row_o,
    output bayer_pkg::col_t         pix_col_o
);

    typedef enum logic {
        SEEK_FRAME,
        CAPTURE
    } state_t;

    state_t          state;
    logic            href_q;
    bayer_pkg::row_t row_cnt;
    bayer_pkg::col_t col_cnt;

    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        if (rst_i) begin
            state       <= SEEK_FRAME;
            href_q      <= 1'b0;
            row_cnt     <= '0;
            col_cnt     <= '0;
            pix_valid_o <= 1'b0;
        end else begin
            href_q      <= href_i;
            pix_valid_o <= 1'b0;
            case (state)
                // nothing is trusted before the first vsync
                SEEK_FRAME: begin
                    if (vsync_i) begin
                        state <= CAPTURE;
                    end
                end
                CAPTURE: begin
                    if (href_i && !vsync_i) begin
                        pix_valid_o <= 1'b1;
                        col_cnt     <= col_cnt + 1'b1;
                    end else if (href_q && !vsync_i) begin
                        // end of line
                        col_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                    end
                end
                default: state <= SEEK_FRAME;
            endcase
            if (vsync_i) begin
                row_cnt <= '0;
                col_cnt <= '0;
            end
        end
    end

    // only the upper nibble is kept
    always_ff @(posedge w_clk_100MHz_to_25MHz) begin
        if (href_i) begin
            pix_o     <= data_i[7:4];
            pix_row_o <= row_cnt;
            pix_col_o <= col_cnt;
        end
    end

    // a line never runs past the frame width
    assert property (@(posedge w_clk_100MHz_to_25MHz) disable iff (rst_i)
        (state == CAPTURE && href_i) |->
            col_cnt < bayer_pkg::col_t'(bayer_pkg::IMAGE_WIDTH));

endmodule

`default_nettype wire

// File: test/tb_bayer_demosaic.sv
`default_nettype none
`timescale 1ns/1ps

module tb_bayer_demosaic;

    localparam int W = bayer_pkg::IMAGE_WIDTH;
    localparam int H = bayer_pkg::IMAGE_HEIGHT;
    localparam int VBLANK_MIN = W + 4;
    localparam int OUT_TIMEOUT = W + 64;
    localparam int RESET_TIMEOUT = 20;
    localparam int SEED = 83;
    localparam int NUM_TESTS = 6;

    // uq1.8 weights of the phase kernels
    localparam int W_ONE = 1 << bayer_pkg::COEFF_FRAC_BITS;
    localparam int W_HALF = W_ONE / 2;
    localparam int W_QUARTER = W_ONE / 4;

    typedef enum logic [1:0] {
        PAT_FLAT,
        PAT_RAMP,
        PAT_CHECKER,
        PAT_RANDOM
    } pattern_t;

    typedef struct packed {
        pattern_t   pattern;
        logic [3:0] value;
        logic       noise;
        int         hblank;
        int         vblank;
    } test_vec_t;

    logic                   w_clk_100MHz_to_25MHz;
    logic                   rst;
    logic                   vsync;
    logic                   href;
    bayer_pkg::raw_t        data;
    logic                   valid;
    bayer_pkg::rgb_t        rgb;
    bayer_pkg::row_t        row;
    bayer_pkg::col_t        col;

    test_vec_t              tests [NUM_TESTS];
    bayer_pkg::raw_t        frame_raw [W * H];
    int                     seed = SEED;
    int                     exp_row = 0;
    int                     exp_col = 0;
    int                     out_count = 0;
    int                     checks = 0;
    int                     errors = 0;
    int                     tests_run = 0;
    bit                     timed_out = 1'b0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o (w_clk_100MHz_to_25MHz),
        .rst_o (rst)
    );

    bayer_demosaic_top i_bayer_demosaic_top (
        .w_clk_100MHz_to_25MHz (w_clk_100MHz_to_25MHz),
        .rst_i                 (rst),
        .vsync_i               (vsync),
        .href_i                (href),
        .data_i                (data),
        .valid_o               (valid),
        .rgb_o                 (rgb),
        .row_o                 (row),
        .col_o                 (col)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // zero outside the frame
    function automatic int nibble_at(input int r, input int c);
        if (r < 0 || r >= H || c < 0 || c >= W) begin
            return 0;
        end
        return int'(frame_raw[r * W + c][7:4]);
    endfunction

    function automatic int weighted_nibble(input int sum, input int weight);
        int v;
        v = (sum * weight) >> bayer_pkg::COEFF_FRAC_BITS;
        return (v > bayer_pkg::PIXEL_MAX) ? bayer_pkg::PIXEL_MAX : v;
    endfunction

    function automatic bayer_pkg::rgb_t expected_rgb(input int r, input int c);
        int ctr;
        int lr;
        int ud;
        int diag;
        int red;
        int blue;
        ctr  = nibble_at(r, c);
        lr   = nibble_at(r, c - 1) + nibble_at(r, c + 1);
        ud   = nibble_at(r - 1, c) + nibble_at(r + 1, c);
        diag = nibble_at(r - 1, c - 1) + nibble_at(r - 1, c + 1) +
               nibble_at(r + 1, c - 1) + nibble_at(r + 1, c + 1);
        case ({r % 2 == 1, c % 2 == 1})
            2'b11: begin
                red  = weighted_nibble(ctr, W_ONE);
                blue = weighted_nibble(diag, W_QUARTER);
            end
            2'b10: begin
                red  = weighted_nibble(lr, W_HALF);
                blue = weighted_nibble(ud, W_HALF);
            end
            2'b01: begin
                red  = weighted_nibble(ud, W_HALF);
                blue = weighted_nibble(lr, W_HALF);
            end
            default: begin
                red  = weighted_nibble(diag, W_QUARTER);
                blue = weighted_nibble(ctr, W_ONE);
            end
        endcase
        return {4'(red), 4'(ctr), 4'(blue)};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_rgb(input bayer_pkg::rgb_t got, input bayer_pkg::rgb_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: rgb at row %0d col %0d is %h, expected %h",
                     $time, exp_row, exp_col, got, exp);
        end
    endtask

    task automatic check_pos(input bayer_pkg::row_t got_row, input bayer_pkg::col_t got_col);
        checks++;
        if (got_row !== bayer_pkg::row_t'(exp_row) || got_col !== bayer_pkg::col_t'(exp_col)) begin
            errors++;
            $display("** Error at time %0t: output at row %0d col %0d, expected row %0d col %0d",
                     $time, got_row, got_col, exp_row, exp_col);
        end
    endtask

    task automatic check_count(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("** Error at time %0t: %0d outputs, expected %0d", $time, got, exp);
        end
    endtask

    // outputs are taken at the falling edge, away from the DUT updates
    always @(negedge w_clk_100MHz_to_25MHz) begin
        if (!rst && valid) begin
            check_pos(row, col);
            check_rgb(rgb, expected_rgb(exp_row, exp_col));
            out_count++;
            if (exp_col == W - 1) begin
                exp_col = 0;
                exp_row++;
            end else begin
                exp_col++;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    task automatic build_frame(input pattern_t pattern, input logic [3:0] value, input bit noise);
        int frame_seed;
        logic [3:0] hi;
        logic [3:0] lo;
        // both random frames share their upper nibbles
        frame_seed = SEED + value;
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                case (pattern)
                    PAT_FLAT:    hi = value;
                    PAT_RAMP:    hi = 4'((c >> 3) + value);
                    PAT_CHECKER: hi = ((r + c) % 2 == 1) ? value : ~value;
                    default:     hi = 4'($random(frame_seed));
                endcase
                lo = noise ? 4'($random(seed)) : 4'h0;
                frame_raw[r * W + c] = {hi, lo};
            end
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge w_clk_100MHz_to_25MHz);
            vsync <= 1'b0;
            href  <= 1'b0;
            data  <= '0;
        end
    endtask

    task automatic send_frame(input int hblank);
        repeat (4) begin
            @(posedge w_clk_100MHz_to_25MHz);
            vsync <= 1'b1;
            href  <= 1'b0;
        end
        idle(8);
        for (int r = 0; r < H; r++) begin
            for (int c = 0; c < W; c++) begin
                @(posedge w_clk_100MHz_to_25MHz);
                href <= 1'b1;
                data <= frame_raw[r * W + c];
            end
            if (r != H - 1) begin
                idle(hblank);
            end
        end
    endtask

    // runs through vertical blanking until the frame is out
    task automatic wait_outputs(input int target, output int waited, output bit expired);
        waited  = 0;
        expired = 1'b0;
        while (out_count < target && !expired) begin
            idle(1);
            waited++;
            if (waited >= OUT_TIMEOUT) begin
                expired = 1'b1;
            end
        end
    endtask

    initial begin
        int waited;
        bit expired;
        int errors_before;
        vsync = 1'b0;
        href  = 1'b0;
        data  = '0;
        tests[0] = '{PAT_FLAT,    4'd9,  1'b0, 2,  VBLANK_MIN + 12};
        tests[1] = '{PAT_FLAT,    4'd15, 1'b0, 1,  VBLANK_MIN};
        tests[2] = '{PAT_RAMP,    4'd3,  1'b0, 16, VBLANK_MIN + 40};
        tests[3] = '{PAT_CHECKER, 4'd10, 1'b1, 4,  VBLANK_MIN};
        tests[4] = '{PAT_RANDOM,  4'd0,  1'b0, 3,  VBLANK_MIN};
        tests[5] = '{PAT_RANDOM,  4'd0,  1'b1, 1,  VBLANK_MIN};

        waited = 0;
        while (rst && waited < RESET_TIMEOUT) begin
            @(posedge w_clk_100MHz_to_25MHz);
            waited++;
        end
        if (rst) begin
            timed_out = 1'b1;
            $display("timeout: reset was never released");
        end

        // href before the first vsync, no output expected
        errors_before = errors;
        repeat (3) begin
            for (int i = 0; i < 20; i++) begin
                @(posedge w_clk_100MHz_to_25MHz);
                href <= 1'b1;
                data <= bayer_pkg::raw_t'($random(seed));
            end
            idle(5);
        end
        idle(30);
        check_count(out_count, 0);
        tests_run++;
        $display("test startup: %0d outputs, %0d errors", out_count, errors - errors_before);

        for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
            errors_before = errors;
            build_frame(tests[t].pattern, tests[t].value, tests[t].noise);
            out_count = 0;
            exp_row   = 0;
            exp_col   = 0;
            send_frame(tests[t].hblank);
            wait_outputs(W * H, waited, expired);
            if (expired) begin
                timed_out = 1'b1;
                $display("timeout: test %0d gave %0d of %0d outputs within %0d cycles",
                         t, out_count, W * H, OUT_TIMEOUT);
            end else begin
                idle(tests[t].vblank - waited);
                check_count(out_count, W * H);
                tests_run++;
                $display("test %0d %s value %0d noise %0d: %0d outputs, %0d errors", t,
                         tests[t].pattern.name(), tests[t].value, tests[t].noise,
                         out_count, errors - errors_before);
            end
        end

        idle(16);
        $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period
    localparam int HALF_PERIOD_NS = 5;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o;
        end
    end

    // reset held over the first two rising edges
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire
